//--- cpu_pkg.sv
/*
 * cpu package
 * widths, memory sizing and the opcode, ALU and forwarding
 * encodings shared by the pipeline stages
 */
package cpu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int pc_step    = 4;
  localparam int dmem_words = 64; // word index from address bits 7:2

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    op_arith     = 7'b0110011,
    op_arith_imm = 7'b0010011,
    op_load      = 7'b0000011,
    op_store     = 7'b0100011,
    op_branch    = 7'b1100011,
    op_system    = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_e;

  // operand source for the execute muxes
  typedef enum logic [1:0] {
    fwd_none = 2'd0, // value read in decode
    fwd_mem  = 2'd1, // EX/MEM ALU result
    fwd_wb   = 2'd2  // MEM/WB result
  } fwd_sel_e;

endpackage

//--- fetch_stage.sv
/*
 * fetch stage
 * program counter and IF/ID register, static not-taken fetch
 */
module fetch_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall,
  input  logic                     flush,
  input  logic                     freeze,
  input  logic [cpu_pkg::xlen-1:0] branch_target,
  output logic [cpu_pkg::xlen-1:0] imem_addr,
  input  logic [cpu_pkg::xlen-1:0] imem_data,
  output logic [cpu_pkg::xlen-1:0] if_pc,
  output logic [cpu_pkg::xlen-1:0] if_inst
);
  import cpu_pkg::*;

  logic [xlen-1:0] pc;
  logic            frozen; // ecall seen in decode, nothing more to fetch
  logic            hold;

  assign imem_addr = pc;
  assign hold      = freeze | frozen;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= '0;
      frozen <= 1'b0;
    end else begin
      frozen <= frozen | (freeze & ~flush); // a flushed ecall does not halt
      if (flush)
        pc <= branch_target;
      else if (!(stall || hold))
        pc <= pc + pc_step;
    end
  end

  // IF/ID, zero word acts as the bubble
  always_ff @(posedge clk) begin
    if (reset || flush || hold) begin
      if_inst <= '0;
    end else if (!stall) begin
      if_inst <= imem_data;
      if_pc   <= pc;
    end
  end

endmodule

//--- decode_stage.sv
/*
 * decode stage
 * control decode, immediate generation, source tracking for
 * the hazard unit, and the ID/EX register
 */
module decode_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           flush,
  input  logic [cpu_pkg::xlen-1:0]       if_pc,
  input  logic [cpu_pkg::xlen-1:0]       if_inst,
  output logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [cpu_pkg::xlen-1:0]       rs1_data,
  input  logic [cpu_pkg::xlen-1:0]       rs2_data,
  output logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
  output logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
  output logic                           id_uses_rs2,
  output logic                           id_is_ecall,
  output logic [cpu_pkg::xlen-1:0]       ex_pc,
  output logic [cpu_pkg::reg_addr_w-1:0] ex_rs1,
  output logic [cpu_pkg::reg_addr_w-1:0] ex_rs2,
  output logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
  output logic [cpu_pkg::xlen-1:0]       ex_rs1_data,
  output logic [cpu_pkg::xlen-1:0]       ex_rs2_data,
  output logic [cpu_pkg::xlen-1:0]       ex_imm,
  output cpu_pkg::alu_op_e               ex_alu_op,
  output logic                           ex_alu_src,
  output logic                           ex_branch,
  output logic                           ex_branch_ne,
  output logic                           ex_mem_read,
  output logic                           ex_mem_write,
  output logic                           ex_reg_write,
  output logic                           ex_is_ecall
);
  import cpu_pkg::*;

  opcode_e         opcode;
  alu_op_e         d_alu_op;
  logic [xlen-1:0] d_imm;
  logic            d_alu_src, d_branch, d_mem_read, d_mem_write, d_reg_write;
  logic            d_uses_rs1;

  // funct3 to ALU op, bit 30 picks sub for register forms
  function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic is_sub);
    case (funct3)
      3'b000:  return is_sub ? alu_sub : alu_add;
      3'b010:  return alu_slt;
      3'b110:  return alu_or;
      3'b111:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  assign opcode   = opcode_e'(if_inst[6:0]);
  assign rs1_addr = if_inst[19:15];
  assign rs2_addr = if_inst[24:20];
  assign id_rs1   = d_uses_rs1 ? if_inst[19:15] : '0; // unused sources never match
  assign id_rs2   = id_uses_rs2 ? if_inst[24:20] : '0;

  always_comb begin
    d_alu_op    = alu_add;
    d_alu_src   = 1'b0;
    d_branch    = 1'b0;
    d_mem_read  = 1'b0;
    d_mem_write = 1'b0;
    d_reg_write = 1'b0;
    d_uses_rs1  = 1'b0;
    id_uses_rs2 = 1'b0;
    id_is_ecall = 1'b0;
    case (opcode)
      op_arith: begin
        d_alu_op    = arith_op(if_inst[14:12], if_inst[30]);
        d_reg_write = 1'b1;
        d_uses_rs1  = 1'b1;
        id_uses_rs2 = 1'b1;
      end
      op_arith_imm: begin
        d_alu_op    = arith_op(if_inst[14:12], 1'b0);
        d_alu_src   = 1'b1;
        d_reg_write = 1'b1;
        d_uses_rs1  = 1'b1;
      end
      op_load: begin
        d_alu_src   = 1'b1; // address = rs1 + imm
        d_mem_read  = 1'b1;
        d_reg_write = 1'b1;
        d_uses_rs1  = 1'b1;
      end
      op_store: begin
        d_alu_src   = 1'b1;
        d_mem_write = 1'b1;
        d_uses_rs1  = 1'b1;
        id_uses_rs2 = 1'b1; // store data
      end
      op_branch: begin
        d_branch    = 1'b1;
        d_uses_rs1  = 1'b1;
        id_uses_rs2 = 1'b1;
      end
      op_system: id_is_ecall = 1'b1;
      default: ; // bubble or unsupported word
    endcase
  end

  always_comb begin
    case (opcode)
      op_store:  d_imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      op_branch: d_imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
                          if_inst[30:25], if_inst[11:8], 1'b0};
      default:   d_imm = {{20{if_inst[31]}}, if_inst[31:20]};
    endcase
  end

  // ID/EX
  always_ff @(posedge clk) begin
    if (reset || stall || flush) begin
      ex_branch    <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_is_ecall  <= 1'b0;
    end else begin
      ex_branch    <= d_branch;
      ex_mem_read  <= d_mem_read;
      ex_mem_write <= d_mem_write;
      ex_reg_write <= d_reg_write;
      ex_is_ecall  <= id_is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc        <= if_pc;
    ex_rs1       <= id_rs1;
    ex_rs2       <= id_rs2;
    ex_rd        <= if_inst[11:7];
    ex_rs1_data  <= rs1_data;
    ex_rs2_data  <= rs2_data;
    ex_imm       <= d_imm;
    ex_alu_op    <= d_alu_op;
    ex_alu_src   <= d_alu_src;
    ex_branch_ne <= if_inst[12]; // funct3 001 is bne
  end

endmodule

//--- reg_file.sv
/*
 * register file
 * 32 x 32, x0 reads zero, a same-cycle write is seen by the read ports
 */
module reg_file (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [cpu_pkg::xlen-1:0]       rs1_data,
  output logic [cpu_pkg::xlen-1:0]       rs2_data,
  input  logic                           wr_en,
  input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [cpu_pkg::xlen-1:0]       wr_data
);
  import cpu_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_w; i++)
        regs[i] <= '0;
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // bypass covers writeback and decode in the same cycle
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

//--- hazard_unit.sv
/*
 * hazard unit
 * forwarding selects for execute and load-use stall for decode
 */
module hazard_unit (
  input  logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
  input  logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
  input  logic                           id_uses_rs2,
  input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs1,
  input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs2,
  input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
  input  logic                           ex_mem_read,
  input  logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
  input  logic                           mem_reg_write,
  input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
  input  logic                           wb_reg_write,
  output cpu_pkg::fwd_sel_e              fwd_a,
  output cpu_pkg::fwd_sel_e              fwd_b,
  output logic                           stall
);
  import cpu_pkg::*;

  // youngest producer wins
  function automatic fwd_sel_e pick_src(input logic [reg_addr_w-1:0] src);
    if (mem_reg_write && mem_rd != '0 && mem_rd == src)
      return fwd_mem;
    else if (wb_reg_write && wb_rd != '0 && wb_rd == src)
      return fwd_wb;
    else
      return fwd_none;
  endfunction

  always_comb begin
    fwd_a = pick_src(ex_rs1);
    fwd_b = pick_src(ex_rs2);
  end

  // load result not ready until MEM, hold decode one cycle
  assign stall = ex_mem_read && (ex_rd != '0) &&
                 ((ex_rd == id_rs1) || (id_uses_rs2 && ex_rd == id_rs2));

endmodule

//--- execute_stage.sv
/*
 * execute stage
 * operand forwarding, ALU, branch resolution and the EX/MEM register
 */
module execute_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [cpu_pkg::xlen-1:0]       ex_pc,
  input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
  input  logic [cpu_pkg::xlen-1:0]       ex_rs1_data,
  input  logic [cpu_pkg::xlen-1:0]       ex_rs2_data,
  input  logic [cpu_pkg::xlen-1:0]       ex_imm,
  input  cpu_pkg::alu_op_e               ex_alu_op,
  input  logic                           ex_alu_src,
  input  logic                           ex_branch,
  input  logic                           ex_branch_ne,
  input  logic                           ex_mem_read,
  input  logic                           ex_mem_write,
  input  logic                           ex_reg_write,
  input  logic                           ex_is_ecall,
  input  cpu_pkg::fwd_sel_e              fwd_a,
  input  cpu_pkg::fwd_sel_e              fwd_b,
  input  logic [cpu_pkg::xlen-1:0]       wb_result,
  output logic                           flush,
  output logic [cpu_pkg::xlen-1:0]       branch_target,
  output logic [cpu_pkg::xlen-1:0]       mem_alu_out,
  output logic [cpu_pkg::xlen-1:0]       mem_store_data,
  output logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
  output logic                           mem_mem_read,
  output logic                           mem_mem_write,
  output logic                           mem_reg_write,
  output logic                           mem_is_ecall
);
  import cpu_pkg::*;

  logic [xlen-1:0] op_a, rs2_fwd, op_b, alu_result;

  always_comb begin
    case (fwd_a)
      fwd_mem: op_a = mem_alu_out;
      fwd_wb:  op_a = wb_result;
      default: op_a = ex_rs1_data;
    endcase
    case (fwd_b)
      fwd_mem: rs2_fwd = mem_alu_out;
      fwd_wb:  rs2_fwd = wb_result;
      default: rs2_fwd = ex_rs2_data;
    endcase
  end

  assign op_b = ex_alu_src ? ex_imm : rs2_fwd;

  always_comb begin
    case (ex_alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  // beq/bne compare the forwarded registers, not the ALU result
  assign flush         = ex_branch & ((op_a == rs2_fwd) ^ ex_branch_ne);
  assign branch_target = ex_pc + ex_imm;

  // EX/MEM
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_is_ecall  <= 1'b0;
    end else begin
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
      mem_is_ecall  <= ex_is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    mem_alu_out    <= alu_result;
    mem_store_data <= rs2_fwd;
    mem_rd         <= ex_rd;
  end

endmodule

//--- memory_stage.sv
/*
 * memory stage
 * data memory, MEM/WB register, retire port and halt latch
 */
module memory_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [cpu_pkg::xlen-1:0]       mem_alu_out,
  input  logic [cpu_pkg::xlen-1:0]       mem_store_data,
  input  logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
  input  logic                           mem_mem_read,
  input  logic                           mem_mem_write,
  input  logic                           mem_reg_write,
  input  logic                           mem_is_ecall,
  output logic [cpu_pkg::xlen-1:0]       wb_result,
  output logic                           wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
  output logic [cpu_pkg::xlen-1:0]       wb_data,
  output logic                           halted
);
  import cpu_pkg::*;

  logic [xlen-1:0]                 dmem [dmem_words];
  logic [$clog2(dmem_words)-1:0]   dmem_idx;
  logic                            wb_reg_write, wb_is_ecall;

  assign dmem_idx = mem_alu_out[$clog2(dmem_words)+1:2]; // word address

  always_ff @(posedge clk) begin
    if (mem_mem_write)
      dmem[dmem_idx] <= mem_store_data;
  end

  // MEM/WB, load data picked here so WB carries one value
  always_ff @(posedge clk) begin
    wb_result <= mem_mem_read ? dmem[dmem_idx] : mem_alu_out;
    wb_rd     <= mem_rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      wb_is_ecall  <= 1'b0;
      halted       <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
      wb_is_ecall  <= mem_is_ecall;
      halted       <= halted | wb_is_ecall; // sticky until reset
    end
  end

  assign wb_valid = wb_reg_write && (wb_rd != '0);
  assign wb_data  = wb_result;

endmodule

//--- pipe_cpu.sv
/*
 * pipe_cpu
 * five-stage RV32I subset pipeline, instruction memory outside,
 * register writes reported on the writeback port
 */
module pipe_cpu (
  input  logic                           clk,
  input  logic                           reset,
  output logic [cpu_pkg::xlen-1:0]       imem_addr,
  input  logic [cpu_pkg::xlen-1:0]       imem_data,
  output logic                           wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
  output logic [cpu_pkg::xlen-1:0]       wb_data,
  output logic                           halted
);
  import cpu_pkg::*;

  logic [xlen-1:0]       if_pc, if_inst, branch_target;
  logic                  stall, flush;
  logic [reg_addr_w-1:0] rs1_addr, rs2_addr, id_rs1, id_rs2;
  logic [xlen-1:0]       rs1_data, rs2_data;
  logic                  id_uses_rs2, id_is_ecall;
  // ID/EX
  logic [xlen-1:0]       ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
  logic [reg_addr_w-1:0] ex_rs1, ex_rs2, ex_rd;
  alu_op_e               ex_alu_op;
  logic                  ex_alu_src, ex_branch, ex_branch_ne;
  logic                  ex_mem_read, ex_mem_write, ex_reg_write, ex_is_ecall;
  fwd_sel_e              fwd_a, fwd_b;
  // EX/MEM
  logic [xlen-1:0]       mem_alu_out, mem_store_data, wb_result;
  logic [reg_addr_w-1:0] mem_rd;
  logic                  mem_mem_read, mem_mem_write, mem_reg_write, mem_is_ecall;

  fetch_stage u_fetch (
    .clk, .reset, .stall, .flush, .freeze(id_is_ecall), .branch_target,
    .imem_addr, .imem_data, .if_pc, .if_inst
  );

  decode_stage u_decode (
    .clk, .reset, .stall, .flush, .if_pc, .if_inst,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .id_rs1, .id_rs2, .id_uses_rs2, .id_is_ecall,
    .ex_pc, .ex_rs1, .ex_rs2, .ex_rd, .ex_rs1_data, .ex_rs2_data, .ex_imm,
    .ex_alu_op, .ex_alu_src, .ex_branch, .ex_branch_ne,
    .ex_mem_read, .ex_mem_write, .ex_reg_write, .ex_is_ecall
  );

  // written from MEM/WB, same signals as the retire port
  reg_file u_regs (
    .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data)
  );

  hazard_unit u_hazard (
    .id_rs1, .id_rs2, .id_uses_rs2, .ex_rs1, .ex_rs2, .ex_rd, .ex_mem_read,
    .mem_rd, .mem_reg_write, .wb_rd, .wb_reg_write(wb_valid),
    .fwd_a, .fwd_b, .stall
  );

  execute_stage u_execute (
    .clk, .reset, .ex_pc, .ex_rd, .ex_rs1_data, .ex_rs2_data, .ex_imm,
    .ex_alu_op, .ex_alu_src, .ex_branch, .ex_branch_ne,
    .ex_mem_read, .ex_mem_write, .ex_reg_write, .ex_is_ecall,
    .fwd_a, .fwd_b, .wb_result, .flush, .branch_target,
    .mem_alu_out, .mem_store_data, .mem_rd,
    .mem_mem_read, .mem_mem_write, .mem_reg_write, .mem_is_ecall
  );

  memory_stage u_memory (
    .clk, .reset, .mem_alu_out, .mem_store_data, .mem_rd,
    .mem_mem_read, .mem_mem_write, .mem_reg_write, .mem_is_ecall,
    .wb_result, .wb_valid, .wb_rd, .wb_data, .halted
  );

endmodule

//--- cpu_asserts.sv
/*
 * pipeline control assertions
 * watch the execute flush and the hazard unit stall inside pipe_cpu
 */
module cpu_asserts (
  input logic clk,
  input logic reset,
  input logic flush,
  input logic stall,
  input logic ex_reg_write,
  input logic ex_mem_write
);

  // execute holds a bubble right after any reset edge
  flush_in_reset: assert property (@(posedge clk) reset |=> !flush)
    else $error("flush high while the pipeline comes out of reset");

  stall_one_cycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
    else $error("load-use stall lasted two cycles in a row");

  stall_bubble: assert property (@(posedge clk) disable iff (reset)
      stall |=> !(ex_reg_write || ex_mem_write))
    else $error("bubble after a stall carries a register or memory write");

endmodule

bind pipe_cpu cpu_asserts u_asserts (
  .clk, .reset, .flush, .stall, .ex_reg_write, .ex_mem_write
);

//--- cpu_tb.sv
/*
 * cpu testbench
 * supplies the program from the pattern file to pipe_cpu and checks
 * every register write against the expected list until halt
 */
module cpu_tb;
  import cpu_pkg::*;

  logic                  clk;
  logic                  reset;
  logic [xlen-1:0]       imem_addr;
  logic [xlen-1:0]       imem_data;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;
  logic                  halted;

  logic [31:0] patterns [256]; // counts, program, then rd/value pairs
  int          prog_len;
  int          exp_count;
  int          seen;        // writes checked so far
  int          cycles;
  int          cycle_limit;

  pipe_cpu uut (
    .clk, .reset, .imem_addr, .imem_data, .wb_valid, .wb_rd, .wb_data, .halted
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] pattern_at(input int pos);
    return patterns[8'(pos)];
  endfunction

  // program word at a byte address, nop past the end
  function automatic logic [xlen-1:0] fetch_word(input logic [xlen-1:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len)
      return pattern_at(2 + idx);
    return 32'h0000_0013; // addi x0, x0, 0
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_write();
    logic [31:0]           exp_word;
    logic [reg_addr_w-1:0] exp_rd;
    logic [xlen-1:0]       exp_data;
    int                    base;
    base = 2 + prog_len + 2 * seen;
    assert (seen < exp_count)
      else stop_with_failure($sformatf(
        "write to x%0d at time %0t comes after the last expected write", wb_rd, $time));
    exp_word = pattern_at(base);
    exp_rd   = exp_word[reg_addr_w-1:0];
    exp_data = pattern_at(base + 1);
    assert (wb_rd == exp_rd)
      else stop_with_failure($sformatf("mismatch at %0t: wb_rd = %0d, expected %0d",
                                       $time, wb_rd, exp_rd));
    assert (wb_data == exp_data)
      else stop_with_failure($sformatf("mismatch at %0t: wb_data = %h, expected %h",
                                       $time, wb_data, exp_data));
    seen++;
  endtask

  task automatic end_run();
    if (seen == exp_count) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_with_failure($sformatf("halted after %0d of %0d expected writes", seen, exp_count));
    end
  endtask

  initial begin
    reset     = 1'b1;
    imem_data = 32'h0000_0013;
    seen      = 0;
    cycles    = 0;
    $readmemh("cpu_patterns.txt", patterns);
    prog_len    = int'(patterns[0]);
    exp_count   = int'(patterns[1]);
    cycle_limit = 4 * prog_len + 50; // generous bound on stalls and flushes
    if (prog_len == 0) begin
      stop_with_failure("pattern file is missing or holds no program");
    end else begin
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
    end
  end

  // instruction for the pc that the last edge produced
  always @(posedge clk) begin
    #1;
    imem_data = fetch_word(imem_addr);
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (wb_valid)
        check_write();
      if (halted)
        end_run();
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycles++;
      if (cycles > cycle_limit)
        stop_with_failure($sformatf("timeout: halted still low after %0d cycles", cycle_limit));
    end
  end

endmodule

//--- cpu_patterns.txt
// word 0: program length, word 1: expected write count (hex)
// then one instruction per line, then expected writes as rd value
16 0d
05a00093 // addi x1, x0, 90
03c00113 // addi x2, x0, 60
002081b3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
0021f2b3 // and  x5, x3, x2
0020e333 // or   x6, x1, x2
40110533 // sub  x10, x2, x1
001523b3 // slt  x7, x10, x1
0020a433 // slt  x8, x1, x2
00302423 // sw   x3, 8(x0)
00802583 // lw   x11, 8(x0)
00458633 // add  x12, x11, x4
00220663 // beq  x4, x2, +12 taken
00100793 // addi x15, x0, 1 skipped
00200793 // addi x15, x0, 2 skipped
00109463 // bne  x1, x1, +8 not taken
00700813 // addi x16, x0, 7
00181663 // bne  x16, x1, +12 taken
00100893 // addi x17, x0, 1 skipped
00200893 // addi x17, x0, 2 skipped
fff80913 // addi x18, x16, -1
00000073 // ecall
01 0000005a
02 0000003c
03 00000096
04 0000003c
05 00000014
06 0000007e
0a ffffffe2
07 00000001
08 00000000
0b 00000096
0c 000000d2
10 00000007
12 00000006

//--- src.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
pipe_cpu.sv
cpu_asserts.sv
cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
